// ==== verification/core_stimulus.txt ====
// ir0 wb0 ir1 wb1 gap   (hex words and values, - = no write-back)
// gap 1 = random idle cycles before the packet, 0 = back to back
60800123 00000123 61000FFB FFFFFFFB 1
71800ABC ABC00000 12044000 0000011E 1
22844000 00000128 430C2000 ABC00123 1
538C4000 543FFFFB 34082000 00000123 1
64840001 00000124 15252000 00000248 1
60040007 0000012A 15802000 00000123 1
00000000 - 660007FF 000007FF 1
66B00001 00000800 00000000 - 1
67380001 00000001 67380001 00000002 0
67380001 00000003 67380001 00000004 0
67380001 00000005 67380001 00000006 0
67380001 00000007 67380001 00000008 0
67380001 00000009 67380001 0000000A 0
67380001 0000000B 67380001 0000000C 0
67380001 0000000D 67380001 0000000E 0

// ==== sources.f ====
source/isa_pkg.sv
source/pipe_pkg.sv
source/instr_buffer.sv
source/instr_decoder.sv
source/register_file.sv
source/issue_execute.sv
source/dual_issue_core.sv
verification/tb_clock_gen.sv
verification/core_checker.sv
verification/tb_dual_issue_core.sv

// ==== verification/tb_dual_issue_core.sv ====
`timescale 1ns/1ps

module tb_dual_issue_core;
    import isa_pkg::*;
    import pipe_pkg::*;

    localparam int ISSUE_WIDTH  = 2;
    localparam int ACCEPT_LIMIT = 50;      // cycles a packet may be held off
    localparam int DRAIN_LIMIT  = 200;

    logic        clk;
    logic        i_reset;
    fetch_slot_t i_fetch [ISSUE_WIDTH];
    logic        o_full;
    wb_t         o_wb [ISSUE_WIDTH];
    wb_t         expected_q [$];           // program order, nops left out
    logic [31:0] lfsr_state;
    word_t       pc;
    int          mismatch_count;
    int          failure_count;
    logic        timed_out;
    logic        saw_full;

    tb_clock_gen #(.PERIOD_NS(20.0)) u_clock_gen (.o_clk(clk));

    dual_issue_core #(.ISSUE_WIDTH(ISSUE_WIDTH), .BUFFER_DEPTH(8)) i_dual_issue_core (
        .clk(clk), .i_reset(i_reset), .i_fetch(i_fetch), .o_full(o_full), .o_wb(o_wb)
    );

    // fibonacci, taps 32 22 2 1
    function automatic logic next_random_bit();
        logic feedback;
        feedback   = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
        lfsr_state = {lfsr_state[30:0], feedback};
        return feedback;
    endfunction

    task automatic queue_expected(input word_t ir, input string token);
        wb_t   entry;
        word_t value;
        if (token != "-") begin
            void'($sscanf(token, "%h", value));
            entry.valid = 1'b1;
            entry.rd    = ir[RD_LSB +: 5];
            entry.value = value;
            expected_q.push_back(entry);
        end
    endtask

    task automatic check_writeback(input wb_t got);
        wb_t want;
        assert (expected_q.size() != 0) else begin
            failure_count++;
            $display("unexpected write-back to r%0d at %0t", got.rd, $time);
        end
        if (expected_q.size() != 0) begin
            want = expected_q.pop_front();
            assert (got == want) else begin
                mismatch_count++;
                $display("mismatch at %0t: rd %0d expected %h, got rd %0d value %h",
                         $time, want.rd, want.value, got.rd, got.value);
            end
        end
    endtask

    // called 2 ns after an edge, returns at the same offset
    task automatic send_packet(input word_t ir0, input word_t ir1);
        int   waited;
        logic held;
        waited           = 0;
        i_fetch[0].valid = 1'b1;
        i_fetch[0].pc    = pc;
        i_fetch[0].ir    = ir0;
        i_fetch[1].valid = 1'b1;
        i_fetch[1].pc    = pc + 32'd4;
        i_fetch[1].ir    = ir1;
        do begin
            held     = o_full;             // level for the coming edge
            saw_full = saw_full | held;
            @(posedge clk);
            #2;
            waited++;
        end while (held && waited < ACCEPT_LIMIT);
        if (held) begin
            timed_out = 1'b1;
            failure_count++;
            $display("timeout: packet at pc %h was never accepted", pc);
        end
        i_fetch[0].valid = 1'b0;
        i_fetch[1].valid = 1'b0;
        pc               = pc + 32'd8;
    endtask

    // o_wb is stable between edges
    always @(negedge clk) begin
        if (!i_reset) begin
            for (int k = 0; k < ISSUE_WIDTH; k++) begin
                if (o_wb[k].valid) begin
                    check_writeback(o_wb[k]);
                end
            end
        end
    end

    ////////////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////////////
    initial begin
        int         fd;
        int         status;
        int         waited;
        int         gap_flag;
        logic [1:0] gap;
        string      line;
        string      tok0;
        string      tok1;
        word_t      ir0;
        word_t      ir1;
        lfsr_state     = 32'hcfc9_eac4;
        pc             = '0;
        mismatch_count = 0;
        failure_count  = 0;
        timed_out      = 1'b0;
        saw_full       = 1'b0;
        i_reset        = 1'b1;
        i_fetch[0]     = '0;
        i_fetch[1]     = '0;
        repeat (5) @(posedge clk);
        #2;
        i_reset = 1'b0;
        assert (!o_full && !o_wb[0].valid && !o_wb[1].valid) else begin
            failure_count++;
            $display("core is not idle after reset");
        end

        fd = $fopen("verification/core_stimulus.txt", "r");
        if (fd == 0) begin
            failure_count++;
            $display("cannot open verification/core_stimulus.txt");
        end else begin
            while (!$feof(fd) && !timed_out) begin
                status = $fgets(line, fd);
                if (status == 0 || line.len() < 8 || line.substr(0, 1) == "//") begin
                    continue;
                end
                status = $sscanf(line, "%h %s %h %s %d", ir0, tok0, ir1, tok1, gap_flag);
                if (status != 5) begin
                    failure_count++;
                    $display("malformed stimulus line: %s", line);
                    continue;
                end
                queue_expected(ir0, tok0);
                queue_expected(ir1, tok1);
                if (gap_flag != 0) begin
                    gap[1] = next_random_bit();
                    gap[0] = next_random_bit();
                    repeat (gap) begin
                        @(posedge clk);
                        #2;
                    end
                end
                send_packet(ir0, ir1);
            end
            $fclose(fd);
        end

        waited = 0;
        while (expected_q.size() != 0 && waited < DRAIN_LIMIT && !timed_out) begin
            @(posedge clk);
            waited++;
        end
        if (expected_q.size() != 0) begin
            failure_count++;
            $display("timeout: %0d write-backs never arrived", expected_q.size());
        end
        repeat (4) @(posedge clk);         // catch stray write-backs
        assert (saw_full) else begin
            failure_count++;
            $display("o_full never went high during the back-to-back burst");
        end

        $display("errors: %0d mismatches, %0d other failures", mismatch_count, failure_count);
        if (mismatch_count == 0 && failure_count == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

// ==== verification/core_checker.sv ====
`timescale 1ns/1ps

module core_checker #(
    parameter int ISSUE_WIDTH  = 2,
    parameter int BUFFER_DEPTH = 8
) (
    input logic                              clk,
    input logic                              i_reset,
    input pipe_pkg::fetch_slot_t             i_head [ISSUE_WIDTH],
    input logic [$clog2(ISSUE_WIDTH+1)-1:0]  i_issue_count,
    input logic [$clog2(BUFFER_DEPTH+1)-1:0] i_occupancy,
    input pipe_pkg::wb_t                     i_wb [ISSUE_WIDTH]
);
    int   valid_heads;
    logic any_wb;

    always_comb begin
        valid_heads = 0;
        any_wb      = 1'b0;
        for (int k = 0; k < ISSUE_WIDTH; k++) begin
            valid_heads = valid_heads + int'(i_head[k].valid);
            any_wb      = any_wb | i_wb[k].valid;
        end
    end

    // can only issue what the buffer shows
    issue_within_head: assert property (@(posedge clk) disable iff (i_reset)
        int'(i_issue_count) <= valid_heads)
        else $error("issue count %0d above %0d valid head slots", i_issue_count, valid_heads);

    quiet_after_reset: assert property (@(posedge clk) i_reset |=> !any_wb)
        else $error("write-back valid in the cycle after reset");

    occupancy_bound: assert property (@(posedge clk) disable iff (i_reset)
        int'(i_occupancy) <= BUFFER_DEPTH)
        else $error("buffer occupancy %0d above depth", i_occupancy);

endmodule

bind dual_issue_core core_checker #(.ISSUE_WIDTH(ISSUE_WIDTH), .BUFFER_DEPTH(BUFFER_DEPTH))
    u_core_checker (.clk(clk), .i_reset(i_reset), .i_head(head), .i_issue_count(issue_count),
                    .i_occupancy(u_instr_buffer.occupancy), .i_wb(o_wb));

// ==== verification/tb_clock_gen.sv ====
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter real PERIOD_NS = 20.0
) (
    output logic o_clk
);
    initial begin
        o_clk = 1'b0;
        forever #(PERIOD_NS / 2.0) o_clk = ~o_clk;
    end

endmodule

// ==== source/dual_issue_core.sv ====
`timescale 1ns/1ps

module dual_issue_core #(
    parameter int ISSUE_WIDTH  = 2,
    parameter int BUFFER_DEPTH = 8
) (
    input  logic                  clk,
    input  logic                  i_reset,
    input  pipe_pkg::fetch_slot_t i_fetch [ISSUE_WIDTH],   // slot 0 oldest
    output logic                  o_full,
    output pipe_pkg::wb_t         o_wb [ISSUE_WIDTH]
);
    import isa_pkg::*;
    import pipe_pkg::*;

    localparam int COUNT_WIDTH = $clog2(ISSUE_WIDTH + 1);

    fetch_slot_t            head [ISSUE_WIDTH];
    decoded_t               decoded [ISSUE_WIDTH];
    reg_addr_t              raddr [2*ISSUE_WIDTH];
    word_t                  rdata [2*ISSUE_WIDTH];
    logic [COUNT_WIDTH-1:0] issue_count;

    instr_buffer #(
        .ISSUE_WIDTH  (ISSUE_WIDTH),
        .BUFFER_DEPTH (BUFFER_DEPTH)
    ) u_instr_buffer (
        .clk           (clk),
        .i_reset       (i_reset),
        .i_fetch       (i_fetch),
        .i_issue_count (issue_count),
        .o_head        (head),
        .o_full        (o_full)
    );

    // one decoder per issue lane
    for (genvar k = 0; k < ISSUE_WIDTH; k++) begin : g_decode
        instr_decoder u_instr_decoder (
            .i_slot    (head[k]),
            .o_decoded (decoded[k])
        );
    end

    register_file #(
        .ISSUE_WIDTH (ISSUE_WIDTH)
    ) u_register_file (
        .clk     (clk),
        .i_reset (i_reset),
        .i_raddr (raddr),
        .i_wb    (o_wb),        // same registered results as the top output
        .o_rdata (rdata)
    );

    issue_execute #(
        .ISSUE_WIDTH (ISSUE_WIDTH)
    ) u_issue_execute (
        .clk           (clk),
        .i_reset       (i_reset),
        .i_decoded     (decoded),
        .i_rdata       (rdata),
        .o_raddr       (raddr),
        .o_issue_count (issue_count),
        .o_wb          (o_wb)
    );

endmodule

// ==== source/issue_execute.sv ====
`timescale 1ns/1ps

module issue_execute #(
    parameter int ISSUE_WIDTH = 2
) (
    input  logic                             clk,
    input  logic                             i_reset,
    input  isa_pkg::decoded_t                i_decoded [ISSUE_WIDTH],
    input  isa_pkg::word_t                   i_rdata [2*ISSUE_WIDTH],
    output isa_pkg::reg_addr_t               o_raddr [2*ISSUE_WIDTH],
    output logic [$clog2(ISSUE_WIDTH+1)-1:0] o_issue_count,
    output pipe_pkg::wb_t                    o_wb [ISSUE_WIDTH]
);
    import isa_pkg::*;

    localparam int COUNT_WIDTH = $clog2(ISSUE_WIDTH + 1);

    logic [ISSUE_WIDTH-1:0] issue;
    word_t                  result [ISSUE_WIDTH];

    function automatic word_t alu(input decoded_t d, input word_t a, input word_t b);
        case (d.opcode)
            op_add:  return a + b;      // wraps at 32 bits
            op_sub:  return a - b;
            op_and:  return a & b;
            op_or:   return a | b;
            op_xor:  return a ^ b;
            op_addi: return a + d.imm;
            op_lui:  return d.imm;
            default: return '0;
        endcase
    endfunction

    ////////////////////////////////////////////////
    // in-order issue selection
    ////////////////////////////////////////////////
    always_comb begin
        logic in_order;
        logic hazard;
        in_order      = 1'b1;
        o_issue_count = '0;
        for (int k = 0; k < ISSUE_WIDTH; k++) begin
            hazard = 1'b0;
            for (int j = 0; j < k; j++) begin
                if (i_decoded[j].writes_rd && (i_decoded[j].rd != '0)) begin
                    if ((i_decoded[j].rd == i_decoded[k].rj) ||
                        (i_decoded[k].uses_rk && (i_decoded[j].rd == i_decoded[k].rk))) begin
                        hazard = 1'b1;  // producer in same packet
                    end
                end
            end
            issue[k]      = in_order && i_decoded[k].valid && !hazard;
            in_order      = issue[k];   // a stalled lane blocks the younger ones
            o_issue_count = o_issue_count + COUNT_WIDTH'(issue[k]);
        end
    end

    // operands straight from the register file
    always_comb begin
        for (int k = 0; k < ISSUE_WIDTH; k++) begin
            o_raddr[2*k]     = i_decoded[k].rj;
            o_raddr[2*k + 1] = i_decoded[k].rk;
            result[k]        = alu(i_decoded[k], i_rdata[2*k], i_rdata[2*k + 1]);
        end
    end

    ////////////////////////////////////////////////
    // write-back register
    ////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        for (int k = 0; k < ISSUE_WIDTH; k++) begin
            o_wb[k].rd    <= i_decoded[k].rd;
            o_wb[k].value <= result[k];
            if (i_reset) begin
                o_wb[k].valid <= 1'b0;
            end else begin
                o_wb[k].valid <= issue[k] && i_decoded[k].writes_rd;  // nop retires silently
            end
        end
    end

endmodule

// ==== source/register_file.sv ====
`timescale 1ns/1ps

module register_file #(
    parameter int ISSUE_WIDTH = 2
) (
    input  logic               clk,
    input  logic               i_reset,
    input  isa_pkg::reg_addr_t i_raddr [2*ISSUE_WIDTH],    // rj, rk per lane
    input  pipe_pkg::wb_t      i_wb [ISSUE_WIDTH],
    output isa_pkg::word_t     o_rdata [2*ISSUE_WIDTH]
);
    import isa_pkg::*;

    localparam int NUM_REGS = 2 ** REG_ADDR_WIDTH;

    word_t regs [NUM_REGS];

    // later lanes are younger, so their write lands last
    always_ff @(posedge clk) begin
        if (i_reset) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else begin
            for (int k = 0; k < ISSUE_WIDTH; k++) begin
                if (i_wb[k].valid && (i_wb[k].rd != '0)) begin
                    regs[i_wb[k].rd] <= i_wb[k].value;
                end
            end
        end
    end

    // results on i_wb were registered at the last edge and already count as written
    always_comb begin
        for (int p = 0; p < 2*ISSUE_WIDTH; p++) begin
            o_rdata[p] = regs[i_raddr[p]];
            for (int k = 0; k < ISSUE_WIDTH; k++) begin
                if (i_wb[k].valid && (i_wb[k].rd == i_raddr[p])) begin
                    o_rdata[p] = i_wb[k].value;    // younger lane wins
                end
            end
            if (i_raddr[p] == '0) begin
                o_rdata[p] = '0;                   // r0 hardwired
            end
        end
    end

endmodule

// ==== source/instr_decoder.sv ====
`timescale 1ns/1ps

module instr_decoder (
    input  pipe_pkg::fetch_slot_t i_slot,
    output isa_pkg::decoded_t     o_decoded
);
    import isa_pkg::*;

    logic [3:0]           raw_op;
    logic [IMM_WIDTH-1:0] raw_imm;
    opcode_e              opcode;

    always_comb begin
        raw_op  = i_slot.ir[OPCODE_LSB +: 4];
        raw_imm = i_slot.ir[IMM_WIDTH-1:0];

        // anything outside the table decodes as nop
        case (opcode_e'(raw_op))
            op_add, op_sub, op_and, op_or, op_xor, op_addi, op_lui: begin
                opcode = opcode_e'(raw_op);
            end
            default: opcode = op_nop;
        endcase
    end

    always_comb begin
        o_decoded.valid     = i_slot.valid;
        o_decoded.opcode    = opcode;
        o_decoded.rd        = i_slot.ir[RD_LSB +: REG_ADDR_WIDTH];
        o_decoded.rj        = i_slot.ir[RJ_LSB +: REG_ADDR_WIDTH];
        o_decoded.rk        = i_slot.ir[RK_LSB +: REG_ADDR_WIDTH];
        o_decoded.uses_rk   = opcode inside {op_add, op_sub, op_and, op_or, op_xor};
        o_decoded.writes_rd = (opcode != op_nop);

        case (opcode)
            op_addi: o_decoded.imm = {{(DATA_WIDTH-IMM_WIDTH){raw_imm[IMM_WIDTH-1]}}, raw_imm};
            op_lui:  o_decoded.imm = {raw_imm, {(DATA_WIDTH-IMM_WIDTH){1'b0}}};  // upper bits
            default: o_decoded.imm = '0;
        endcase
    end

endmodule

// ==== source/instr_buffer.sv ====
`timescale 1ns/1ps

module instr_buffer #(
    parameter int ISSUE_WIDTH  = 2,
    parameter int BUFFER_DEPTH = 8
) (
    input  logic                               clk,
    input  logic                               i_reset,
    input  pipe_pkg::fetch_slot_t              i_fetch [ISSUE_WIDTH],
    input  logic [$clog2(ISSUE_WIDTH+1)-1:0]   i_issue_count,
    output pipe_pkg::fetch_slot_t              o_head [ISSUE_WIDTH],
    output logic                               o_full
);
    import pipe_pkg::*;

    localparam int PTR_W       = $clog2(BUFFER_DEPTH);   // depth is a power of two
    localparam int CNT_W       = $clog2(BUFFER_DEPTH + 1);
    localparam int COUNT_WIDTH = $clog2(ISSUE_WIDTH + 1);

    fetch_slot_t            mem [BUFFER_DEPTH];
    logic [PTR_W-1:0]       rd_ptr;
    logic [PTR_W-1:0]       wr_ptr;
    logic [CNT_W-1:0]       occupancy;
    logic [COUNT_WIDTH-1:0] slot_offset [ISSUE_WIDTH];
    logic [COUNT_WIDTH-1:0] push_count;
    logic [COUNT_WIDTH-1:0] push_amount;
    logic                   push;

    // full when a whole packet no longer fits
    assign o_full = (occupancy > CNT_W'(BUFFER_DEPTH - ISSUE_WIDTH));

    ////////////////////////////////////////////////
    // packet compaction
    ////////////////////////////////////////////////
    always_comb begin
        push_count = '0;
        for (int k = 0; k < ISSUE_WIDTH; k++) begin
            slot_offset[k] = push_count;    // valid slots before this one
            push_count     = push_count + COUNT_WIDTH'(i_fetch[k].valid);
        end
        push        = (push_count != '0) && !o_full;
        push_amount = push ? push_count : '0;
    end

    always_ff @(posedge clk) begin
        if (push) begin
            for (int k = 0; k < ISSUE_WIDTH; k++) begin
                if (i_fetch[k].valid) begin
                    mem[wr_ptr + PTR_W'(slot_offset[k])] <= i_fetch[k];
                end
            end
        end
    end

    ////////////////////////////////////////////////
    // pointers and occupancy
    ////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (i_reset) begin
            rd_ptr    <= '0;
            wr_ptr    <= '0;
            occupancy <= '0;
        end else begin
            rd_ptr    <= rd_ptr + PTR_W'(i_issue_count);
            wr_ptr    <= wr_ptr + PTR_W'(push_amount);
            occupancy <= occupancy + CNT_W'(push_amount) - CNT_W'(i_issue_count);
        end
    end

    // oldest entries, slot 0 first
    always_comb begin
        for (int k = 0; k < ISSUE_WIDTH; k++) begin
            o_head[k]       = mem[rd_ptr + PTR_W'(k)];
            o_head[k].valid = (occupancy > k);  // stale entries masked
        end
    end

endmodule

// ==== source/pipe_pkg.sv ====
package pipe_pkg;

    ////////////////////////////////////////////////
    // pipeline transport structs
    ////////////////////////////////////////////////

    // one instruction from the fetch side, 65 bits
    typedef struct packed {
        logic          valid;
        isa_pkg::word_t pc;
        isa_pkg::word_t ir;
    } fetch_slot_t;

    // registered result of one lane, 38 bits
    typedef struct packed {
        logic              valid;
        isa_pkg::reg_addr_t rd;
        isa_pkg::word_t     value;
    } wb_t;

endpackage

// ==== source/isa_pkg.sv ====
package isa_pkg;

    localparam int DATA_WIDTH     = 32;
    localparam int REG_ADDR_WIDTH = 5;

    ////////////////////////////////////////////////
    // instruction word layout
    // [31:28] opcode  [27:23] rd  [22:18] rj
    // [17:13] rk      [12] spare  [11:0] imm
    ////////////////////////////////////////////////
    localparam int OPCODE_LSB = 28;
    localparam int RD_LSB     = 23;
    localparam int RJ_LSB     = 18;
    localparam int RK_LSB     = 13;
    localparam int IMM_WIDTH  = 12;     // imm sits at bit 0

    typedef enum logic [3:0] {
        op_nop  = 4'h0,
        op_add  = 4'h1,
        op_sub  = 4'h2,
        op_and  = 4'h3,
        op_or   = 4'h4,
        op_xor  = 4'h5,
        op_addi = 4'h6,
        op_lui  = 4'h7
    } opcode_e;

    typedef logic [REG_ADDR_WIDTH-1:0] reg_addr_t;
    typedef logic [DATA_WIDTH-1:0]     word_t;

    // one decode lane's result, 54 bits
    typedef struct packed {
        logic      valid;
        opcode_e   opcode;
        reg_addr_t rd;
        reg_addr_t rj;
        reg_addr_t rk;
        logic      uses_rk;     // three-register ops only
        logic      writes_rd;
        word_t     imm;         // already extended / shifted
    } decoded_t;

endpackage
